/* src/gremlin_isa_pkg.sv */
`default_nettype none

package gremlin_isa_pkg;

  // --------------------------------------------------
  // opcodes and operand modes
  // --------------------------------------------------
  typedef enum logic [3:0] {
    ADD_C0    = 4'h0,  // carry in 0
    ADD_C1    = 4'h1,  // carry in 1
    ADD_CSAVE = 4'h2,  // carry from last add
    ADD_CCUR  = 4'h3,  // carry of adder right now
    LD_TIME   = 4'h4,
    LD_IN0    = 4'h5,
    LD_IN1    = 4'h6,
    LD_IN2    = 4'h7,
    STORE     = 4'h8,
    OUT0      = 4'h9,
    OUT1      = 4'ha,
    OUT2      = 4'hb,
    SET_INDEX = 4'hc,  // index from acc low byte
    AND_OP    = 4'hd,
    OR_OP     = 4'he,
    XOR_OP    = 4'hf
  } gremlin_op_e;

  typedef enum logic [1:0] {
    MEM     = 2'd0,
    MEM_INV = 2'd1,
    ZERO    = 2'd2,
    ONES    = 2'd3
  } operand_mode_e;

  // --------------------------------------------------
  // instruction word, two views
  // --------------------------------------------------
  typedef struct packed {
    logic          branch;   // 0 here
    operand_mode_e mode;
    logic          indexed;  // address is index + addr
    gremlin_op_e   op;
    logic [7:0]    addr;
  } alu_instr_t;

  typedef struct packed {
    logic       branch;      // 1 here
    logic [6:0] unused;
    logic [7:0] target;      // taken when acc != 0
  } branch_instr_t;

  typedef union packed {
    alu_instr_t    alu;
    branch_instr_t br;
  } gremlin_instr_u;

  // one set of three ports, in or out
  typedef struct packed {
    logic [15:0] port2;
    logic [15:0] port1;
    logic [15:0] port0;
  } core_ports_t;

  // acc | 0 leaves everything untouched
  localparam logic [15:0] NOP_WORD = {1'b0, ZERO, 1'b0, OR_OP, 8'h00};

endpackage

`default_nettype wire

/* src/gremlin_bus_pkg.sv */
`default_nettype none

package gremlin_bus_pkg;

  localparam int CORE_ADDR_W = 4;
  localparam int AXIL_ADDR_W = 12 + CORE_ADDR_W;  // word, target, core fields

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // --------------------------------------------------
  // AXI4-Lite channels
  // --------------------------------------------------
  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic [31:0]            wdata;
    logic [3:0]             wstrb;
    logic                   wvalid;
    logic                   bready;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

  // --------------------------------------------------
  // host address map
  // --------------------------------------------------
  typedef enum logic [1:0] {
    PROG_MEM = 2'd0,
    DATA_MEM = 2'd1,
    CTRL     = 2'd2
  } host_sel_e;

  typedef struct packed {
    logic [CORE_ADDR_W-1:0] core;
    host_sel_e              sel;
    logic [7:0]             word;
    logic [1:0]             byte_off;  // dropped, word access only
  } host_addr_t;

  // one cycle request towards a single core
  typedef struct packed {
    logic        we;
    logic        re;
    host_sel_e   sel;
    logic [7:0]  addr;
    logic [15:0] data;
  } mem_req_t;

endpackage

`default_nettype wire

/* src/gremlin_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module gremlin_ram (
  input  logic        CLK,
  input  logic        we_i,
  input  logic [7:0]  waddr_i,
  input  logic [15:0] wdata_i,
  input  logic        re_i,
  input  logic [7:0]  raddr_i,
  output logic [15:0] rdata_o
);

  logic [15:0] mem_q [256];

  always_ff @(posedge CLK)
  begin
    if (we_i)
      mem_q[waddr_i] <= wdata_i;
    if (re_i)
      rdata_o <= mem_q[raddr_i];  // holds while re_i is low
  end

endmodule

`default_nettype wire

/* src/gremlin_core.sv */
`timescale 1ns/1ps
`default_nettype none

module gremlin_core
  import gremlin_isa_pkg::*;
  import gremlin_bus_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  mem_req_t    mem_req_i,
  input  logic        run_clr_i,
  input  core_ports_t in_ports_i,
  output core_ports_t out_ports_o,
  output logic [15:0] rdata_o,
  output logic [31:0] status_o
);

  gremlin_instr_u fetch_w, instr_f_q, instr_o_q;
  logic [7:0]  ip_q, ip_nxt, index_q, dmem_raddr, dmem_waddr;
  logic [15:0] acc_q, opnd_q, input_q, timer_q, opnd_hold_q, ctrl_rd_q;
  logic [15:0] dmem_rdata, dmem_wdata, dmem_word, adder_sum;
  logic [31:0] status_q;
  logic [2:0]  out_flag_q, out_set;
  logic        run_q, pause_q, rd_dmem_q, add_carry_q, save_carry_q, cur_carry;
  logic        host_act, core_en, exec_alu, branch_taken, dmem_re, dmem_we;

  assign host_act = mem_req_i.we | mem_req_i.re;  // host owns the memories
  assign core_en  = run_q & ~host_act;
  assign exec_alu = core_en & ~instr_o_q.alu.branch;

  assign branch_taken = instr_o_q.br.branch && (acc_q != 16'd0);
  assign ip_nxt = !run_q ? 8'd0 :
                  branch_taken ? instr_o_q.br.target : ip_q + 8'd1;

  // --------------------------------------------------
  // memories
  // --------------------------------------------------
  gremlin_ram prog_mem (
    .CLK     (CLK),
    .we_i    (mem_req_i.we && mem_req_i.sel == PROG_MEM),
    .waddr_i (mem_req_i.addr),
    .wdata_i (mem_req_i.data),
    .re_i    (~host_act),  // paused core keeps its word
    .raddr_i (ip_nxt),
    .rdata_o (fetch_w)
  );

  assign dmem_re = (mem_req_i.re && mem_req_i.sel == DATA_MEM) ||
                   (core_en && !fetch_w.alu.branch && fetch_w.alu.mode inside {MEM, MEM_INV});
  assign dmem_we = (mem_req_i.we && mem_req_i.sel == DATA_MEM) ||
                   (exec_alu && instr_o_q.alu.op == STORE);
  assign dmem_raddr = host_act ? mem_req_i.addr :
                      fetch_w.alu.indexed ? index_q + fetch_w.alu.addr : fetch_w.alu.addr;
  assign dmem_waddr = host_act ? mem_req_i.addr :
                      instr_o_q.alu.indexed ? index_q + instr_o_q.alu.addr : instr_o_q.alu.addr;
  assign dmem_wdata = host_act ? mem_req_i.data : acc_q;

  gremlin_ram data_mem (
    .CLK     (CLK),
    .we_i    (dmem_we),
    .waddr_i (dmem_waddr),
    .wdata_i (dmem_wdata),
    .re_i    (dmem_re),
    .raddr_i (dmem_raddr),
    .rdata_o (dmem_rdata)
  );

  // a host read overwrote the operand, use the saved copy
  assign dmem_word = pause_q ? opnd_hold_q : dmem_rdata;

  assign {cur_carry, adder_sum} = {1'b0, acc_q} + {1'b0, opnd_q} + {16'h0, add_carry_q};

  assign out_set[0] = exec_alu && instr_o_q.alu.op == OUT0;
  assign out_set[1] = exec_alu && instr_o_q.alu.op == OUT1;
  assign out_set[2] = exec_alu && instr_o_q.alu.op == OUT2;

  // --------------------------------------------------
  // control state
  // --------------------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      run_q      <= 1'b0;
      pause_q    <= 1'b0;
      out_flag_q <= '0;
      timer_q    <= '0;
    end
    else
    begin
      if (mem_req_i.we && mem_req_i.sel == CTRL && mem_req_i.addr == 8'd0)
        run_q <= mem_req_i.data[0];
      pause_q    <= host_act;
      out_flag_q <= (out_flag_q & ~{3{run_clr_i}}) | out_set;  // new write beats clear
      timer_q    <= timer_q - 16'd1;  // free running
    end
  end

  always_ff @(posedge CLK)
  begin
    if (host_act && !pause_q)
      opnd_hold_q <= dmem_rdata;
    if (mem_req_i.re)
    begin
      rd_dmem_q <= (mem_req_i.sel == DATA_MEM);
      status_q  <= '0;
      ctrl_rd_q <= '0;
      if (mem_req_i.sel == CTRL)
        case (mem_req_i.addr)
          8'd0: status_q <= {timer_q, 12'h000, out_flag_q, run_q};
          8'd1: ctrl_rd_q <= out_ports_o.port0;
          8'd2: ctrl_rd_q <= out_ports_o.port1;
          8'd3: ctrl_rd_q <= out_ports_o.port2;
          default: ;
        endcase
    end
  end

  assign rdata_o  = rd_dmem_q ? dmem_rdata : ctrl_rd_q;
  assign status_o = status_q;

  // --------------------------------------------------
  // pipeline
  // --------------------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      ip_q         <= '0;
      instr_f_q    <= NOP_WORD;
      instr_o_q    <= NOP_WORD;
      acc_q        <= '0;
      index_q      <= '0;
      add_carry_q  <= 1'b0;
      save_carry_q <= 1'b0;
      out_ports_o  <= '0;
    end
    else if (!run_q)
    begin
      ip_q      <= '0;
      instr_f_q <= NOP_WORD;
      instr_o_q <= NOP_WORD;
    end
    else if (!host_act)
    begin
      ip_q      <= ip_nxt;
      instr_f_q <= fetch_w;
      instr_o_q <= instr_f_q;
      if (!instr_f_q.alu.branch)  // stage f, operand and carry
      begin
        case (instr_f_q.alu.mode)
          MEM:     opnd_q <= dmem_word;
          MEM_INV: opnd_q <= ~dmem_word;
          ZERO:    opnd_q <= 16'h0000;
          ONES:    opnd_q <= 16'hffff;
        endcase
        case (instr_f_q.alu.op)
          ADD_C0:    add_carry_q <= 1'b0;
          ADD_C1:    add_carry_q <= 1'b1;
          ADD_CSAVE: add_carry_q <= save_carry_q;
          ADD_CCUR:  add_carry_q <= cur_carry;
          LD_IN0:    input_q <= in_ports_i.port0;
          LD_IN1:    input_q <= in_ports_i.port1;
          LD_IN2:    input_q <= in_ports_i.port2;
          default: ;
        endcase
      end
      if (!instr_o_q.alu.branch)  // stage o, execute
        case (instr_o_q.alu.op)
          ADD_C0, ADD_C1, ADD_CSAVE, ADD_CCUR:
          begin
            acc_q        <= adder_sum;
            save_carry_q <= cur_carry;
          end
          LD_TIME:                acc_q <= timer_q;
          LD_IN0, LD_IN1, LD_IN2: acc_q <= input_q;
          OUT0:                   out_ports_o.port0 <= acc_q;
          OUT1:                   out_ports_o.port1 <= acc_q;
          OUT2:                   out_ports_o.port2 <= acc_q;
          SET_INDEX:              index_q <= acc_q[7:0];
          AND_OP:                 acc_q <= acc_q & opnd_q;
          OR_OP:                  acc_q <= acc_q | opnd_q;
          XOR_OP:                 acc_q <= acc_q ^ opnd_q;
          default: ;  // store goes through the data write port
        endcase
    end
  end

endmodule

`default_nettype wire

/* src/gremlin_host_if.sv */
`timescale 1ns/1ps
`default_nettype none

module gremlin_host_if
  import gremlin_bus_pkg::*;
#(
  parameter int NUM_CORES = 4
)
(
  input  logic                          CLK,
  input  logic                          RST,
  input  axil_req_t                     axil_req_i,
  output axil_rsp_t                     axil_rsp_o,
  output mem_req_t [NUM_CORES-1:0]      mem_req_o,
  output logic [CORE_ADDR_W-1:0]        rd_core_o,
  output logic                          rd_pending_o,
  output logic                          rd_err_o
);

  localparam logic [1:0] RD_IDLE = 2'd0;
  localparam logic [1:0] RD_REQ  = 2'd1;  // request at the core
  localparam logic [1:0] RD_DATA = 2'd2;  // core data registered
  localparam logic [1:0] RD_RESP = 2'd3;  // R valid, waiting for rready

  host_addr_t  aw_addr, ar_addr, wr_addr_q, rd_addr_q;
  logic [15:0] wr_data_q;
  logic [1:0]  bresp_q, rd_stage_q;
  logic        wr_accept, rd_accept, wr_req_q, wr_err_q, bvalid_q, rd_err_q;

  assign aw_addr = host_addr_t'(axil_req_i.awaddr);
  assign ar_addr = host_addr_t'(axil_req_i.araddr);

  assign wr_accept = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
  // never let a read request land in the same cycle as a write
  assign rd_accept = axil_req_i.arvalid & (rd_stage_q == RD_IDLE) & ~wr_accept;

  always_comb
  begin
    axil_rsp_o         = '0;
    axil_rsp_o.awready = wr_accept;
    axil_rsp_o.wready  = wr_accept;
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.arready = rd_accept;
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      wr_req_q   <= 1'b0;
      bvalid_q   <= 1'b0;
      rd_stage_q <= RD_IDLE;
    end
    else
    begin
      wr_req_q <= wr_accept;
      if (wr_accept)
        bvalid_q <= 1'b1;
      else if (axil_req_i.bready)
        bvalid_q <= 1'b0;
      case (rd_stage_q)
        RD_IDLE: if (rd_accept) rd_stage_q <= RD_REQ;
        RD_REQ:  rd_stage_q <= RD_DATA;
        RD_DATA: rd_stage_q <= RD_RESP;
        RD_RESP: if (axil_req_i.rready) rd_stage_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (wr_accept)
    begin
      wr_addr_q <= aw_addr;
      wr_data_q <= axil_req_i.wdata[15:0];  // upper half dropped
      wr_err_q  <= int'(aw_addr.core) >= NUM_CORES;
      bresp_q   <= (int'(aw_addr.core) >= NUM_CORES) ? RESP_SLVERR : RESP_OKAY;
    end
    if (rd_accept)
    begin
      rd_addr_q <= ar_addr;
      rd_err_q  <= int'(ar_addr.core) >= NUM_CORES;
    end
  end

  always_comb
  begin
    for (int i = 0; i < NUM_CORES; i++)
    begin
      mem_req_o[i].we   = wr_req_q & ~wr_err_q & (int'(wr_addr_q.core) == i);
      mem_req_o[i].re   = (rd_stage_q == RD_REQ) & ~rd_err_q & (int'(rd_addr_q.core) == i);
      mem_req_o[i].sel  = wr_req_q ? wr_addr_q.sel : rd_addr_q.sel;
      mem_req_o[i].addr = wr_req_q ? wr_addr_q.word : rd_addr_q.word;
      mem_req_o[i].data = wr_data_q;
    end
  end

  assign rd_core_o    = rd_addr_q.core;
  assign rd_pending_o = (rd_stage_q == RD_REQ);
  assign rd_err_o     = rd_err_q;

endmodule

`default_nettype wire

/* src/gremlin_collect.sv */
`timescale 1ns/1ps
`default_nettype none

module gremlin_collect
  import gremlin_bus_pkg::*;
#(
  parameter int NUM_CORES = 4
)
(
  input  logic                            CLK,
  input  logic                            RST,
  input  logic [NUM_CORES-1:0][15:0]      core_rdata_i,
  input  logic [NUM_CORES-1:0][31:0]      core_status_i,
  input  logic [CORE_ADDR_W-1:0]          rd_core_i,
  input  logic                            rd_pending_i,
  input  logic                            rd_err_i,
  input  logic                            rready_i,
  output logic [31:0]                     rdata_o,
  output logic [1:0]                      rresp_o,
  output logic                            rvalid_o
);

  logic [CORE_ADDR_W-1:0] sel_q;
  logic [31:0]            sel_word;
  logic                   fire_q, err_q;

  // core data shows up one cycle after the request
  always_ff @(posedge CLK)
  begin
    if (!RST)
      fire_q <= 1'b0;
    else
      fire_q <= rd_pending_i;
    sel_q <= rd_core_i;
    err_q <= rd_err_i;
  end

  // status is zero unless CTRL word 0 was read
  always_comb
  begin
    sel_word = '0;
    for (int i = 0; i < NUM_CORES; i++)
      if (sel_q == CORE_ADDR_W'(i))
        sel_word = core_status_i[i] | {16'h0000, core_rdata_i[i]};
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
      rvalid_o <= 1'b0;
    else if (fire_q)
      rvalid_o <= 1'b1;
    else if (rready_i)
      rvalid_o <= 1'b0;  // held until taken
    if (fire_q)
    begin
      rdata_o <= err_q ? 32'h0 : sel_word;
      rresp_o <= err_q ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

/* src/gremlin_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module gremlin_cluster
  import gremlin_isa_pkg::*;
  import gremlin_bus_pkg::*;
#(
  parameter int NUM_CORES = 4
)
(
  input  logic        CLK,
  input  logic        RST,
  input  axil_req_t   axil_req_i,
  output axil_rsp_t   axil_rsp_o,
  input  core_ports_t in_ports_i [NUM_CORES],
  output core_ports_t out_ports_o [NUM_CORES]
);

  axil_rsp_t                   hif_rsp;
  mem_req_t [NUM_CORES-1:0]    mem_req;
  logic [NUM_CORES-1:0][15:0]  core_rdata;
  logic [NUM_CORES-1:0][31:0]  core_status;
  logic [CORE_ADDR_W-1:0]      rd_core;
  logic [31:0]                 col_rdata;
  logic [1:0]                  col_rresp;
  logic                        rd_pending, rd_err, col_rvalid;

  gremlin_host_if #(.NUM_CORES(NUM_CORES)) host_if_i (
    .CLK          (CLK),
    .RST          (RST),
    .axil_req_i   (axil_req_i),
    .axil_rsp_o   (hif_rsp),
    .mem_req_o    (mem_req),
    .rd_core_o    (rd_core),
    .rd_pending_o (rd_pending),
    .rd_err_o     (rd_err)
  );

  for (genvar g = 0; g < NUM_CORES; g++)
  begin : g_core
    gremlin_core core_i (
      .CLK         (CLK),
      .RST         (RST),
      .mem_req_i   (mem_req[g]),
      // status read clears the sticky flags
      .run_clr_i   (mem_req[g].re && mem_req[g].sel == CTRL && mem_req[g].addr == 8'd0),
      .in_ports_i  (in_ports_i[g]),
      .out_ports_o (out_ports_o[g]),
      .rdata_o     (core_rdata[g]),
      .status_o    (core_status[g])
    );
  end

  gremlin_collect #(.NUM_CORES(NUM_CORES)) collect_i (
    .CLK           (CLK),
    .RST           (RST),
    .core_rdata_i  (core_rdata),
    .core_status_i (core_status),
    .rd_core_i     (rd_core),
    .rd_pending_i  (rd_pending),
    .rd_err_i      (rd_err),
    .rready_i      (axil_req_i.rready),
    .rdata_o       (col_rdata),
    .rresp_o       (col_rresp),
    .rvalid_o      (col_rvalid)
  );

  // R channel comes from the collector
  always_comb
  begin
    axil_rsp_o        = hif_rsp;
    axil_rsp_o.rdata  = col_rdata;
    axil_rsp_o.rresp  = col_rresp;
    axil_rsp_o.rvalid = col_rvalid;
  end

endmodule

`default_nettype wire

/* testbench/tb_axil_tasks.svh */
task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
  int n;
  axil_req.awaddr  = addr;
  axil_req.awvalid = 1'b1;
  axil_req.wdata   = data;
  axil_req.wstrb   = 4'hf;
  axil_req.wvalid  = 1'b1;
  axil_req.bready  = 1'b1;
  n = 0;
  @(negedge CLK);
  while (!(axil_rsp.awready && axil_rsp.wready))
  begin
    n++;
    if (n > WAIT_LIMIT)
      abort_run("AXI write address and data were never accepted");
    @(negedge CLK);
  end
  @(posedge CLK);  // AW and W taken here
  #2;
  axil_req.awvalid = 1'b0;
  axil_req.wvalid  = 1'b0;
  n = 0;
  @(negedge CLK);
  while (!axil_rsp.bvalid)
  begin
    n++;
    if (n > WAIT_LIMIT)
      abort_run("AXI write response never arrived");
    @(negedge CLK);
  end
  resp = axil_rsp.bresp;
  @(posedge CLK);  // B taken here
  #2;
  axil_req.bready = 1'b0;
endtask

task automatic axil_read(input logic [15:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
  int n;
  axil_req.araddr  = addr;
  axil_req.arvalid = 1'b1;
  axil_req.rready  = 1'b1;
  n = 0;
  @(negedge CLK);
  while (!axil_rsp.arready)
  begin
    n++;
    if (n > WAIT_LIMIT)
      abort_run("AXI read address was never accepted");
    @(negedge CLK);
  end
  @(posedge CLK);
  #2;
  axil_req.arvalid = 1'b0;
  n = 0;
  @(negedge CLK);
  while (!axil_rsp.rvalid)
  begin
    n++;
    if (n > WAIT_LIMIT)
      abort_run("AXI read data never arrived");
    @(negedge CLK);
  end
  data = axil_rsp.rdata;
  resp = axil_rsp.rresp;
  @(posedge CLK);  // R taken here
  #2;
  axil_req.rready = 1'b0;
endtask

/* testbench/tb_gremlin_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gremlin_cluster
  import gremlin_isa_pkg::*;
  import gremlin_bus_pkg::*;
();

  localparam int N_CORES    = 4;
  localparam int WAIT_LIMIT = 2000;  // cycles per wait loop

  logic        CLK;
  logic        RST;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  core_ports_t in_ports  [N_CORES];
  core_ports_t out_ports [N_CORES];

  logic [15:0] dmem_model [N_CORES][256];  // what each data memory should hold
  logic [7:0]  load_ptr   [N_CORES];       // next program address per core

  gremlin_cluster #(.NUM_CORES(N_CORES)) dut_i (
    .CLK         (CLK),
    .RST         (RST),
    .axil_req_i  (axil_req),
    .axil_rsp_o  (axil_rsp),
    .in_ports_i  (in_ports),
    .out_ports_o (out_ports)
  );

  initial
  begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // --------------------------------------------------
  // checking and waiting
  // --------------------------------------------------
  task automatic abort_run(input string why);
    $display("Test FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp)
    else
    begin
      $display("FAIL %0d ns: %s, got %h, expected %h", $time, what, got, exp);
      abort_run("a checked value was wrong");
    end
  endtask

  `include "tb_axil_tasks.svh"

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge CLK);
    #2;
  endtask

  function automatic logic [15:0] port_value(input int core, input int port);
    case (port)
      0:       return out_ports[core].port0;
      1:       return out_ports[core].port1;
      default: return out_ports[core].port2;
    endcase
  endfunction

  task automatic wait_port(input int core, input int port, input logic [15:0] value);
    int n;
    n = 0;
    @(negedge CLK);
    while (port_value(core, port) !== value)
    begin
      n++;
      if (n > WAIT_LIMIT)
        abort_run($sformatf("core %0d port %0d never reached %h", core, port, value));
      @(negedge CLK);
    end
    @(posedge CLK);
    #2;
  endtask

  // --------------------------------------------------
  // assembler and host helpers
  // --------------------------------------------------
  function automatic logic [15:0] alu_word(input operand_mode_e mode, input gremlin_op_e op,
                                           input logic [7:0] addr, input logic indexed = 1'b0);
    gremlin_instr_u word;
    word.alu.branch  = 1'b0;
    word.alu.mode    = mode;
    word.alu.indexed = indexed;
    word.alu.op      = op;
    word.alu.addr    = addr;
    return word;
  endfunction

  function automatic logic [15:0] br_word(input logic [7:0] target);
    gremlin_instr_u word;
    word.br.branch = 1'b1;
    word.br.unused = 7'h00;
    word.br.target = target;
    return word;
  endfunction

  function automatic logic [15:0] host_addr(input int core, input host_sel_e sel,
                                            input logic [7:0] word);
    return {4'(core), sel, word, 2'b00};
  endfunction

  task automatic emit(input int core, input logic [15:0] word);
    logic [1:0] resp;
    axil_write(host_addr(core, PROG_MEM, load_ptr[core]), {16'h0000, word}, resp);
    check_eq(32'(resp), 32'(RESP_OKAY), "program write response");
    load_ptr[core] = load_ptr[core] + 8'd1;
  endtask

  // acc forced nonzero, then a branch to itself with two nop slots
  task automatic halt_here(input int core);
    emit(core, alu_word(ONES, OR_OP, 8'h00));
    emit(core, br_word(load_ptr[core]));
    emit(core, NOP_WORD);
    emit(core, NOP_WORD);
  endtask

  task automatic put_data(input int core, input logic [7:0] word, input logic [31:0] data);
    logic [1:0] resp;
    axil_write(host_addr(core, DATA_MEM, word), data, resp);
    check_eq(32'(resp), 32'(RESP_OKAY), "data write response");
    dmem_model[core][word] = data[15:0];
  endtask

  task automatic check_data(input int core, input logic [7:0] word);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(host_addr(core, DATA_MEM, word), data, resp);
    check_eq(32'(resp), 32'(RESP_OKAY), "data read response");
    check_eq(data, {16'h0000, dmem_model[core][word]},
             $sformatf("core %0d data word %0d", core, word));
  endtask

  task automatic set_run(input int core, input logic run);
    logic [1:0] resp;
    axil_write(host_addr(core, CTRL, 8'h00), {31'h0, run}, resp);
    check_eq(32'(resp), 32'(RESP_OKAY), "control write response");
  endtask

  task automatic read_status(input int core, output logic [31:0] status);
    logic [1:0] resp;
    axil_read(host_addr(core, CTRL, 8'h00), status, resp);
    check_eq(32'(resp), 32'(RESP_OKAY), "control read response");
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial
  begin
    logic [31:0] st, rd;
    logic [16:0] sum_c;
    logic [15:0] cnt, xor_exp, d3_out1, d3_out2, tmr;
    logic [15:0] exp_port [N_CORES][3];  // final value of every output port
    logic [7:0]  idx;
    logic [1:0]  resp;
    int          wr_core [16];
    int          wr_word [16];

    void'($urandom(32'hc128c4c6));
    axil_req = '0;
    RST      = 1'b0;
    for (int i = 0; i < N_CORES; i++)
    begin
      in_ports[i] = {16'($urandom), 16'($urandom), 16'($urandom)};
      load_ptr[i] = 8'h00;
      for (int p = 0; p < 3; p++)
        exp_port[i][p] = 16'h0000;
    end
    idle(8);
    RST = 1'b1;
    idle(2);

    // random data words, then read back
    for (int i = 0; i < 16; i++)
    begin
      wr_core[i] = $urandom_range(N_CORES - 1, 0);
      wr_word[i] = $urandom_range(255, 0);
      put_data(wr_core[i], 8'(wr_word[i]), $urandom);
    end
    for (int i = 0; i < 16; i++)
      check_data(wr_core[i], 8'(wr_word[i]));
    axil_write(host_addr(N_CORES, DATA_MEM, 8'h00), $urandom, resp);
    check_eq(32'(resp), 32'(RESP_SLVERR), "write to missing core");
    axil_read(host_addr(N_CORES, DATA_MEM, 8'h00), rd, resp);
    check_eq(32'(resp), 32'(RESP_SLVERR), "read from missing core");
    check_eq(rd, 32'h0, "read data from missing core");

    // core 0 sums words 0 to 3, carry out of each add feeds the next
    sum_c = '0;
    for (int w = 0; w < 4; w++)
    begin
      put_data(0, 8'(w), $urandom);
      sum_c = 17'(sum_c[15:0]) + 17'(dmem_model[0][w]) + 17'(sum_c[16]);
    end
    exp_port[0][0] = sum_c[15:0];
    emit(0, alu_word(ZERO, AND_OP, 8'h00));
    emit(0, alu_word(MEM, ADD_C0, 8'h00));
    for (int w = 1; w < 4; w++)
      emit(0, alu_word(MEM, ADD_CCUR, 8'(w)));
    emit(0, alu_word(ZERO, OUT0, 8'h00));
    halt_here(0);

    // core 1 counts down to zero on port 1, then marks port 0
    cnt = 16'($urandom_range(40, 20));
    put_data(1, 8'h00, 32'(cnt));
    put_data(1, 8'h01, 32'h0);
    exp_port[1][0] = 16'hffff;
    emit(1, alu_word(ZERO, AND_OP, 8'h00));
    emit(1, alu_word(MEM, OR_OP, 8'h00));
    emit(1, alu_word(MEM_INV, ADD_C0, 8'h01));  // loop top at 2, acc minus 1
    emit(1, alu_word(ZERO, OUT1, 8'h00));
    emit(1, br_word(8'd2));
    emit(1, NOP_WORD);
    emit(1, NOP_WORD);
    emit(1, alu_word(ONES, OR_OP, 8'h00));
    emit(1, alu_word(ZERO, OUT0, 8'h00));
    halt_here(1);

    // core 2 stores in2 xor word 1 at index + 5
    idx = 8'($urandom_range(200, 16));
    put_data(2, 8'h00, 32'(idx));
    put_data(2, 8'h01, $urandom);
    xor_exp = in_ports[2].port2 ^ dmem_model[2][1];
    exp_port[2][2] = xor_exp;
    emit(2, alu_word(ZERO, AND_OP, 8'h00));
    emit(2, alu_word(MEM, OR_OP, 8'h00));
    emit(2, alu_word(ZERO, SET_INDEX, 8'h00));
    emit(2, alu_word(ZERO, LD_IN2, 8'h00));
    emit(2, alu_word(MEM, XOR_OP, 8'h01));
    emit(2, alu_word(ZERO, STORE, 8'h05, 1'b1));
    emit(2, alu_word(ZERO, OUT2, 8'h00));
    halt_here(2);

    // core 3 adds with carry in 1 and masks an input
    put_data(3, 8'h00, $urandom);
    put_data(3, 8'h01, $urandom);
    d3_out1 = in_ports[3].port0 + dmem_model[3][0] + 16'd1;
    d3_out2 = in_ports[3].port1 & dmem_model[3][1];
    exp_port[3][1] = d3_out1;
    exp_port[3][2] = d3_out2;
    emit(3, alu_word(ZERO, LD_IN0, 8'h00));
    emit(3, alu_word(MEM, ADD_C1, 8'h00));
    emit(3, alu_word(ZERO, OUT1, 8'h00));
    emit(3, alu_word(ZERO, LD_IN1, 8'h00));
    emit(3, alu_word(MEM, AND_OP, 8'h01));
    emit(3, alu_word(ZERO, OUT2, 8'h00));
    halt_here(3);

    // all cores run while the host reads data
    for (int c = 0; c < N_CORES; c++)
      set_run(c, 1'b1);
    for (int i = 0; i < 12; i++)
      check_data($urandom_range(N_CORES - 1, 0), 8'($urandom_range(1, 0)));

    wait_port(0, 0, sum_c[15:0]);
    wait_port(1, 0, 16'hffff);
    check_eq(32'(out_ports[1].port1), 32'h0, "core 1 final count");
    read_status(1, st);
    check_eq(32'(st[15:0]), 32'h0007, "core 1 status with out flags");
    tmr = st[31:16];
    read_status(1, st);
    check_eq(32'(st[15:0]), 32'h0001, "core 1 status after flag clear");
    check_eq(32'(st[31:16] < tmr), 32'h1, "timer counting down");
    wait_port(2, 2, xor_exp);
    dmem_model[2][idx + 8'd5] = xor_exp;
    check_data(2, idx + 8'd5);
    wait_port(3, 2, d3_out2);
    for (int c = 0; c < N_CORES; c++)
      for (int p = 0; p < 3; p++)
        check_eq(32'(port_value(c, p)), 32'(exp_port[c][p]),
                 $sformatf("core %0d port %0d", c, p));

    // stop core 3, outputs must hold
    set_run(3, 1'b0);
    idle(10);
    read_status(3, st);
    check_eq(32'(st[0]), 32'h0, "core 3 run bit after stop");
    for (int p = 0; p < 3; p++)
    begin
      check_eq(32'(port_value(3, p)), 32'(exp_port[3][p]),
               $sformatf("core 3 port %0d after stop", p));
      axil_read(host_addr(3, CTRL, 8'(p + 1)), rd, resp);
      check_eq(32'(resp), 32'(RESP_OKAY), "port read response");
      check_eq(rd, 32'(exp_port[3][p]), $sformatf("core 3 port %0d read by host", p));
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+testbench
src/gremlin_isa_pkg.sv
src/gremlin_bus_pkg.sv
src/gremlin_ram.sv
src/gremlin_core.sv
src/gremlin_host_if.sv
src/gremlin_collect.sv
src/gremlin_cluster.sv
testbench/tb_gremlin_cluster.sv

/* Makefile */
TOP := tb_gremlin_cluster

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

obj_dir/V$(TOP): filelist.f src/*.sv testbench/*.sv testbench/*.svh
	verilator --binary --timing -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
